// ==== bench/fsb_subsystem_sva.sv ====
// gateway protocol assertions
// bound into every fsb_gateway instance

module fsb_subsystem_sva
   #(parameter bit en_at_start_p = 1'b0
   )
   (input  logic               clk_i
   , input  logic              reset_i
   , input  logic              v_i
   , input  logic              ready_o
   , input  logic              v_o
   , input  fsb_pkg::fsb_item_s item_o
   , input  logic              ready_i
   , input  logic              node_en_r_o
   );

   // link ready only ever answers a valid packet
   a_ready_needs_valid: assert property
      (@(posedge clk_i) disable iff (reset_i) ready_o |-> v_i)
      else $error("gateway raised ready_o without v_i");

   // item held toward the input queue must not move while it waits
   a_stall_stable: assert property
      (@(posedge clk_i) disable iff (reset_i) (v_o && !ready_i) |=> (v_o && $stable(item_o)))
      else $error("gateway item changed while stalled");

   // enable comes out of reset at its start value, low by default
   a_reset_enable: assert property
      (@(posedge clk_i) reset_i |=> (node_en_r_o == en_at_start_p))
      else $error("node enable wrong one cycle after reset");

endmodule

bind fsb_gateway fsb_subsystem_sva #(.en_at_start_p(enabled_at_start_p)) i_sva
   (.clk_i(clk_i), .reset_i(reset_i)
   , .v_i(v_i), .ready_o(ready_o)
   , .v_o(v_o), .item_o(item_o), .ready_i(ready_i)
   , .node_en_r_o(node_en_r_o)
   );

// ==== bench/fsb_subsystem_tb.sv ====
// testbench for the front-side-bus node endpoint
// directed tests of commands, filtering, accumulation and back-pressure

`include "fsb_params.svh"

module fsb_subsystem_tb;

   import fsb_pkg::*;

   localparam logic [`FSB_ID_WIDTH-1:0] node_id_lp = 4'd5;
   localparam int timeout_lp = 200;
   localparam int silence_lp = 20;

   logic clk_i, reset_i;
   logic v_i, ready_o, v_o, ready_i;
   fsb_pkt_s data_i, data_o;
   logic node_en_o, node_reset_o;

   // replies seen on the link output, in arrival order
   fsb_pkt_s reply_q[$];
   // expected running sum
   logic [31:0] sum_model;

   fsb_subsystem #(.node_id_p(node_id_lp)) i_dut
      (.clk_i(clk_i), .reset_i(reset_i)
      , .v_i(v_i), .data_i(data_i), .ready_o(ready_o)
      , .v_o(v_o), .data_o(data_o), .ready_i(ready_i)
      , .node_en_o(node_en_o), .node_reset_o(node_reset_o)
      );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // output monitor
   always @(posedge clk_i)
   begin
      if (!reset_i && v_o && ready_i)
         reply_q.push_back(data_o);
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "run stopped");
   endtask

   task automatic check_eq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
      if (actual !== expected)
         stop_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                            name, actual, expected));
   endtask

   function automatic fsb_pkt_s data_pkt(input logic [`FSB_ID_WIDTH-1:0] dest,
                                         input logic [`FSB_ID_WIDTH-1:0] src,
                                         input logic [31:0] data);
      return '{destid: dest, srcid: src, cmd: 1'b0, opcode: FSB_NOP_CMD, data: data};
   endfunction

   function automatic fsb_pkt_s cmd_pkt(input logic [`FSB_ID_WIDTH-1:0] dest,
                                        input fsb_opcode_e op);
      return '{destid: dest, srcid: '0, cmd: 1'b1, opcode: op, data: '0};
   endfunction

   // random payload from a random sender to this node
   function automatic fsb_pkt_s random_pkt();
      logic [31:0] r;
      r = $urandom();
      return data_pkt(node_id_lp, r[`FSB_ID_WIDTH-1:0], $urandom());
   endfunction

   task automatic drive_pkt(input fsb_pkt_s pkt);
      @(posedge clk_i);
      #1;
      v_i    = 1'b1;
      data_i = pkt;
   endtask

   // ok stays low if no handshake within max_cycles, v_i then still held
   task automatic wait_accept(input int max_cycles, output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < max_cycles && !ok; n++)
      begin
         @(posedge clk_i);
         if (ready_o)
            ok = 1'b1;
      end
      if (ok)
      begin
         #1;
         v_i = 1'b0;
      end
   endtask

   task automatic send_pkt(input fsb_pkt_s pkt);
      bit ok;
      drive_pkt(pkt);
      wait_accept(timeout_lp, ok);
      if (!ok)
         stop_run("timeout: the link never accepted a data packet");
   endtask

   // sunk packets go on the first edge, whatever the queues hold
   task automatic sink_pkt(input fsb_pkt_s pkt);
      bit ok;
      drive_pkt(pkt);
      wait_accept(1, ok);
      if (!ok)
         stop_run("a packet meant to be sunk was not accepted at once");
   endtask

   task automatic expect_reply(input logic [`FSB_ID_WIDTH-1:0] dest);
      fsb_pkt_s got;
      int n;
      n = 0;
      while (reply_q.size() == 0)
      begin
         if (n == timeout_lp)
            stop_run("timeout: no reply came out of the link output");
         @(posedge clk_i);
         n++;
      end
      got = reply_q.pop_front();
      check_eq("data_o.destid", 32'(got.destid), 32'(dest));
      check_eq("data_o.srcid", 32'(got.srcid), 32'(node_id_lp));
      check_eq("data_o.cmd", 32'(got.cmd), 32'd0);
      check_eq("data_o.opcode", 32'(got.opcode), 32'd0);
      check_eq("data_o.data", got.data, sum_model);
   endtask

   task automatic expect_silence();
      int n;
      for (n = 0; n < silence_lp; n++)
      begin
         @(posedge clk_i);
         check_eq("v_o", 32'(v_o), 32'd0);
      end
      check_eq("reply count", 32'(reply_q.size()), 32'd0);
   endtask

   task automatic check_state(input logic en, input logic rst);
      @(posedge clk_i);
      check_eq("node_en_o", 32'(node_en_o), 32'(en));
      check_eq("node_reset_o", 32'(node_reset_o), 32'(rst));
   endtask

   task automatic test_after_reset();
      check_state(1'b0, 1'b1);
      // disabled node sinks its data
      sink_pkt(data_pkt(node_id_lp, 4'd2, 32'h1234_5678));
      expect_silence();
   endtask

   task automatic test_bring_up();
      sink_pkt(cmd_pkt(node_id_lp, FSB_ENABLE_CMD));
      check_state(1'b1, 1'b1);
      sink_pkt(cmd_pkt(node_id_lp, FSB_RESET_DISABLE_CMD));
      check_state(1'b1, 1'b0);
      expect_silence();
   endtask

   task automatic test_accumulate();
      fsb_pkt_s pkt;
      int i;
      for (i = 0; i < 10; i++)
      begin
         pkt = random_pkt();
         sum_model = sum_model + pkt.data;
         send_pkt(pkt);
         expect_reply(pkt.srcid);
      end
   endtask

   task automatic test_filtering();
      fsb_pkt_s pkt;
      sink_pkt(data_pkt(4'd3, 4'd1, 32'hdead_beef));
      sink_pkt(cmd_pkt(4'd3, FSB_DISABLE_CMD));
      sink_pkt(cmd_pkt(4'd3, FSB_RESET_ENABLE_CMD));
      // unknown opcode to this node
      sink_pkt(cmd_pkt(node_id_lp, fsb_opcode_e'(3'b111)));
      check_state(1'b1, 1'b0);
      expect_silence();
      pkt = random_pkt();
      sum_model = sum_model + pkt.data;
      send_pkt(pkt);
      expect_reply(pkt.srcid);
   endtask

   task automatic test_back_pressure();
      fsb_pkt_s pkts[12];
      int i;
      int accepted;
      bit ok;
      for (i = 0; i < 12; i++)
         pkts[i] = random_pkt();
      @(posedge clk_i);
      #1;
      ready_i  = 1'b0;
      accepted = 0;
      ok       = 1'b1;
      while (ok && accepted < 12)
      begin
         drive_pkt(pkts[accepted]);
         wait_accept(silence_lp, ok);
         if (ok)
            accepted++;
      end
      // output queue full, node stalled, input queue full
      check_eq("accepted before stall", 32'(accepted), 32'(2 * `FSB_FIFO_DEPTH));
      // replies wait at the link output
      check_eq("v_o while stalled", 32'(v_o), 32'd1);
      #1;
      ready_i = 1'b1;
      wait_accept(timeout_lp, ok);
      if (!ok)
         stop_run("timeout: held packet not accepted after ready_i came back");
      accepted++;
      while (accepted < 12)
      begin
         send_pkt(pkts[accepted]);
         accepted++;
      end
      for (i = 0; i < 12; i++)
      begin
         sum_model = sum_model + pkts[i].data;
         expect_reply(pkts[i].srcid);
      end
   endtask

   task automatic test_reset_and_disable();
      fsb_pkt_s pkt;
      sink_pkt(cmd_pkt(node_id_lp, FSB_RESET_ENABLE_CMD));
      check_state(1'b1, 1'b1);
      sink_pkt(cmd_pkt(node_id_lp, FSB_RESET_DISABLE_CMD));
      check_state(1'b1, 1'b0);
      // sum starts over after a node reset
      sum_model = '0;
      pkt = random_pkt();
      sum_model = sum_model + pkt.data;
      send_pkt(pkt);
      expect_reply(pkt.srcid);
      sink_pkt(cmd_pkt(node_id_lp, FSB_DISABLE_CMD));
      check_state(1'b0, 1'b0);
      sink_pkt(data_pkt(node_id_lp, 4'd9, 32'h0000_0042));
      expect_silence();
   endtask

   initial
   begin
      void'($urandom(32'hcab05de6));
      reset_i   = 1'b1;
      v_i       = 1'b0;
      data_i    = '0;
      ready_i   = 1'b1;
      sum_model = '0;
      repeat (3) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      test_after_reset();
      test_bring_up();
      test_accumulate();
      test_filtering();
      test_back_pressure();
      test_reset_and_disable();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+source
source/fsb_pkg.sv
source/fsb_gateway.sv
source/fsb_fifo.sv
source/fsb_accum_node.sv
source/fsb_subsystem.sv
bench/fsb_subsystem_sva.sv
bench/fsb_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fsb subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
   --top-module fsb_subsystem_tb -o fsb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/fsb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
   exit 0
fi
exit 1

// ==== source/fsb_accum_node.sv ====
// accumulator node
// adds each data item to a running sum and sends the new sum back
// to the item's sender as a reply packet

`include "fsb_params.svh"

module fsb_accum_node
   #(parameter logic [`FSB_ID_WIDTH-1:0] id_p = '0
   )
   (input  logic                clk_i
   , input  logic               reset_i
   // from the input queue
   , input  logic               v_i
   , input  fsb_pkg::fsb_item_s item_i
   , output logic               yumi_o
   // to the output queue
   , output logic               v_o
   , output fsb_pkg::fsb_pkt_s  pkt_o
   , input  logic               ready_i
   );

   import fsb_pkg::*;

   logic [`FSB_DATA_WIDTH-1:0] sum_r;
   logic [`FSB_DATA_WIDTH-1:0] sum_n;

   // wraps modulo 2^32
   assign sum_n = sum_r + item_i.data;

   // a reply is offered whenever an item waits
   assign v_o = v_i;
   // item popped on the same edge its reply is pushed
   assign yumi_o = v_i & ready_i;

   // reply goes back to the sender, plain data packet
   assign pkt_o = '{destid: item_i.srcid,
                    srcid:  id_p,
                    cmd:    1'b0,
                    opcode: FSB_NOP_CMD,
                    data:   sum_n};

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         sum_r <= '0;
      else if (yumi_o)
         sum_r <= sum_n;
   end

endmodule

// ==== source/fsb_fifo.sv ====
// small synchronous queue
// circular buffer with a registered count, payload given as a type

`include "fsb_params.svh"

module fsb_fifo
   #(parameter type payload_t = logic
   , parameter int depth_p = `FSB_FIFO_DEPTH
   )
   (input  logic     clk_i
   , input  logic    reset_i
   , input  logic    v_i
   , input  payload_t data_i
   , output logic    ready_o
   , output logic    v_o
   , output payload_t data_o
   // pop the head entry
   , input  logic    yumi_i
   );

   localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_width_lp = $clog2(depth_p + 1);

   payload_t mem_r [depth_p];
   logic [ptr_width_lp-1:0] wr_ptr_r, rd_ptr_r;
   logic [cnt_width_lp-1:0] count_r;
   logic full, enq, deq;

   // step a pointer, wrapping at depth_p for any depth
   function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
      if (ptr == ptr_width_lp'(depth_p - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign full    = (count_r == cnt_width_lp'(depth_p));
   // not ready while full or held in reset
   assign ready_o = ~reset_i & ~full;
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];

   assign enq = v_i & ready_o;
   assign deq = yumi_i & v_o;

   // storage
   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wr_ptr_r] <= data_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= next_ptr(wr_ptr_r);
         if (deq)
            rd_ptr_r <= next_ptr(rd_ptr_r);
         // simultaneous push and pop leave the count alone
         count_r <= count_r + cnt_width_lp'(enq) - cnt_width_lp'(deq);
      end
   end

endmodule

// ==== source/fsb_gateway.sv ====
// front-side-bus gateway
// filters link packets by destination id, turns switch commands into the
// node enable and node reset registers, and forwards data for the node

`include "fsb_params.svh"

module fsb_gateway
   #(parameter logic [`FSB_ID_WIDTH-1:0] id_p = '0
   // node comes up enabled and its reset just follows reset_i
   , parameter bit enabled_at_start_p = 1'b0
   )
   (input  logic               clk_i
   , input  logic              reset_i
   // from the link
   , input  logic              v_i
   , input  fsb_pkg::fsb_pkt_s data_i
   , output logic              ready_o
   // to the node side
   , output logic              v_o
   , output fsb_pkg::fsb_item_s item_o
   , input  logic              ready_i
   // switch state
   , output logic              node_en_r_o
   , output logic              node_reset_r_o
   );

   import fsb_pkg::*;

   logic node_en_r, node_en_n;
   logic node_reset_r, node_reset_n;
   logic id_match, for_switch, for_node;

   assign id_match   = (data_i.destid == id_p);
   // command packet addressed to this node
   assign for_switch = v_i & id_match & data_i.cmd;
   // data packet addressed to this node
   assign for_node   = v_i & id_match & ~data_i.cmd;

   // only data for an enabled node goes on to the queue
   assign v_o    = node_en_r & for_node;
   assign item_o = '{srcid: data_i.srcid, data: data_i.data};

   // everything is sunk at once, except data for an enabled node,
   // which waits for room downstream; ready_o never rises without v_i
   assign ready_o = v_i & (~for_node | ~node_en_r | ready_i);

   assign node_en_r_o    = node_en_r;
   assign node_reset_r_o = node_reset_r;

   // command decode, unknown opcodes leave state untouched
   always_comb
   begin
      node_en_n    = node_en_r;
      node_reset_n = node_reset_r;
      if (for_switch)
      begin
         case (data_i.opcode)
            FSB_ENABLE_CMD:        node_en_n    = 1'b1;
            FSB_DISABLE_CMD:       node_en_n    = 1'b0;
            FSB_RESET_ENABLE_CMD:  node_reset_n = 1'b1;
            FSB_RESET_DISABLE_CMD: node_reset_n = 1'b0;
            default:
            begin
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         node_en_r <= enabled_at_start_p;
      else
         node_en_r <= node_en_n;
   end

   generate
      if (enabled_at_start_p)
      begin : g_reset_follow
         // node reset tracks the system reset, delayed one cycle
         always_ff @(posedge clk_i)
         begin
            node_reset_r <= reset_i;
         end
      end
      else
      begin : g_reset_cmd
         // node held in reset until a RESET_DISABLE command
         always_ff @(posedge clk_i)
         begin
            if (reset_i)
               node_reset_r <= 1'b1;
            else
               node_reset_r <= node_reset_n;
         end
      end
   endgenerate

endmodule

// ==== source/fsb_params.svh ====
// front-side-bus node endpoint
// width and depth constants shared by the package and the RTL

`ifndef FSB_PARAMS_SVH
`define FSB_PARAMS_SVH

// node id width, sized for up to 16 nodes
`define FSB_ID_WIDTH 4

// payload width of data packets and the running sum
`define FSB_DATA_WIDTH 32

// default entries per queue
`define FSB_FIFO_DEPTH 4

`endif

// ==== source/fsb_pkg.sv ====
// front-side-bus packet types
// link packet layout, decoded data item and switch command opcodes

`include "fsb_params.svh"

package fsb_pkg;

   // switch commands carried in the opcode field
   // codes not listed here are ignored by the gateway
   typedef enum logic [2:0]
   {
      FSB_NOP_CMD           = 3'b000,
      FSB_ENABLE_CMD        = 3'b001,
      FSB_DISABLE_CMD       = 3'b010,
      FSB_RESET_ENABLE_CMD  = 3'b011,
      FSB_RESET_DISABLE_CMD = 3'b100
   } fsb_opcode_e;

   // full link packet, 44 bits, destid in the top bits
   typedef struct packed
   {
      logic [`FSB_ID_WIDTH-1:0]   destid;
      logic [`FSB_ID_WIDTH-1:0]   srcid;
      // set for switch commands
      logic                       cmd;
      fsb_opcode_e                opcode;
      logic [`FSB_DATA_WIDTH-1:0] data;
   } fsb_pkt_s;

   // data item handed to the node, 36 bits
   typedef struct packed
   {
      logic [`FSB_ID_WIDTH-1:0]   srcid;
      logic [`FSB_DATA_WIDTH-1:0] data;
   } fsb_item_s;

endpackage

// ==== source/fsb_subsystem.sv ====
// front-side-bus node endpoint top level
// gateway feeding an input queue, the accumulator node and an output queue
// back onto the link

`include "fsb_params.svh"

module fsb_subsystem
   #(parameter logic [`FSB_ID_WIDTH-1:0] node_id_p = '0
   )
   (input  logic               clk_i
   , input  logic              reset_i
   // link in
   , input  logic              v_i
   , input  fsb_pkg::fsb_pkt_s data_i
   , output logic              ready_o
   // link out
   , output logic              v_o
   , output fsb_pkg::fsb_pkt_s data_o
   , input  logic              ready_i
   // switch state
   , output logic              node_en_o
   , output logic              node_reset_o
   );

   import fsb_pkg::*;

   // gateway to input queue
   logic      gw_v;
   fsb_item_s gw_item;
   logic      in_ready;
   // input queue to node
   logic      in_v;
   fsb_item_s in_item;
   logic      node_yumi;
   // node to output queue
   logic      node_v;
   fsb_pkt_s  node_pkt;
   logic      out_ready;
   // output queue pop
   logic      out_yumi;
   // node-local reset from the gateway
   logic      node_reset;

   assign node_reset_o = node_reset;
   assign out_yumi     = v_o & ready_i;

   fsb_gateway #(.id_p(node_id_p)) i_gateway
      (.clk_i(clk_i), .reset_i(reset_i)
      , .v_i(v_i), .data_i(data_i), .ready_o(ready_o)
      , .v_o(gw_v), .item_o(gw_item), .ready_i(in_ready)
      , .node_en_r_o(node_en_o), .node_reset_r_o(node_reset)
      );

   // input side runs under the node reset
   fsb_fifo #(.payload_t(fsb_item_s), .depth_p(`FSB_FIFO_DEPTH)) i_in_fifo
      (.clk_i(clk_i), .reset_i(node_reset)
      , .v_i(gw_v), .data_i(gw_item), .ready_o(in_ready)
      , .v_o(in_v), .data_o(in_item), .yumi_i(node_yumi)
      );

   fsb_accum_node #(.id_p(node_id_p)) i_node
      (.clk_i(clk_i), .reset_i(node_reset)
      , .v_i(in_v), .item_i(in_item), .yumi_o(node_yumi)
      , .v_o(node_v), .pkt_o(node_pkt), .ready_i(out_ready)
      );

   // replies already queued survive a node reset
   fsb_fifo #(.payload_t(fsb_pkt_s), .depth_p(`FSB_FIFO_DEPTH)) i_out_fifo
      (.clk_i(clk_i), .reset_i(reset_i)
      , .v_i(node_v), .data_i(node_pkt), .ready_o(out_ready)
      , .v_o(v_o), .data_o(data_o), .yumi_i(out_yumi)
      );

endmodule
